//--- all.f
+incdir+include
design/core_types_pkg.sv
design/instr_accept.sv
design/decoder_1RI20.sv
design/decoder_2RI12.sv
design/decode_stage.sv
design/exec_stage.sv
design/result_sender.sv
design/decode_exec_top.sv
bench/decode_exec_tb.sv

//--- run.sh
#!/bin/sh
# build and run the testbench with Verilator, status follows the result
cd "$(dirname "$0")" && \
verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module decode_exec_tb -o decode_exec_sim && \
./obj_dir/decode_exec_sim | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null && \
echo "simulation passed" || { echo "simulation failed"; exit 1; }

//--- bench/decode_exec_tb.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defines.svh"

module decode_exec_tb
    import core_types::*;
;

    localparam int N_TESTS = 22;

    logic               clk_i;
    logic               rst_n_i;
    logic               req_i;
    logic [`DATA_W-1:0] pc_i;
    instr_word_u        instr_i;
    logic               ack_o;
    logic               res_ack_i;
    logic               res_req_o;
    logic [`GPR_AW-1:0] res_rd_o;
    logic [`DATA_W-1:0] res_value_o;
    logic               res_we_o;
    logic               res_illegal_o;

    // stimulus table
    logic [`DATA_W-1:0] pc_tab    [N_TESTS];
    instr_word_u        instr_tab [N_TESTS];

    // reference register copy and expected results in table order
    logic [`DATA_W-1:0] ref_gpr [`GPR_NUM];
    logic [`GPR_AW-1:0] exp_rd      [$];
    logic [`DATA_W-1:0] exp_value   [$];
    logic               exp_we      [$];
    logic               exp_illegal [$];

    int     mismatch_count = 0;
    int     other_count    = 0;
    int     recv_count     = 0;
    integer seed           = 32'h6622_1c53;

    decode_exec_top UUT (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req_i),
        .pc_i          (pc_i),
        .instr_i       (instr_i),
        .ack_o         (ack_o),
        .res_ack_i     (res_ack_i),
        .res_req_o     (res_req_o),
        .res_rd_o      (res_rd_o),
        .res_value_o   (res_value_o),
        .res_we_o      (res_we_o),
        .res_illegal_o (res_illegal_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic instr_word_u encode_1ri20(input logic [`OPC1_W-1:0] opc,
                                                 input logic [19:0] imm,
                                                 input logic [`GPR_AW-1:0] rd);
        instr_word_u w;
        w.f1ri20.opcode = opc;
        w.f1ri20.imm20  = imm;
        w.f1ri20.rd     = rd;
        return w;
    endfunction

    function automatic instr_word_u encode_2ri12(input logic [`OPC2_W-1:0] opc,
                                                 input logic [11:0] imm,
                                                 input logic [`GPR_AW-1:0] rj,
                                                 input logic [`GPR_AW-1:0] rd);
        instr_word_u w;
        w.f2ri12.opcode = opc;
        w.f2ri12.imm12  = imm;
        w.f2ri12.rj     = rj;
        w.f2ri12.rd     = rd;
        return w;
    endfunction

    task automatic fill_table();
        for (int i = 0; i < N_TESTS; i++) begin
            pc_tab[i] = 32'h1c00_0000 + 32'(4 * i);
        end
        for (int i = 0; i < `GPR_NUM; i++) begin
            ref_gpr[i] = '0;
        end
        // full constant built from lu12i.w then ori, back to back
        instr_tab[0]  = encode_1ri20(`OPC_LU12I_W, 20'h12345, 5'd1);
        instr_tab[1]  = encode_2ri12(`OPC_ORI, 12'h678, 5'd1, 5'd1);
        // pc relative forms, positive and negative
        instr_tab[2]  = encode_1ri20(`OPC_PCADDU12I, 20'h00010, 5'd2);
        instr_tab[3]  = encode_1ri20(`OPC_PCADDI, 20'h00004, 5'd3);
        instr_tab[4]  = encode_1ri20(`OPC_PCADDI, 20'hfffff, 5'd4);
        instr_tab[5]  = encode_1ri20(`OPC_PCADDI, 20'h80000, 5'd5);
        instr_tab[6]  = encode_1ri20(`OPC_PCADDU12I, 20'hfffff, 5'd6);
        // sign vs zero extension of imm12
        instr_tab[7]  = encode_2ri12(`OPC_ADDI_W, 12'h800, 5'd1, 5'd7);
        instr_tab[8]  = encode_2ri12(`OPC_ADDI_W, 12'h7ff, 5'd7, 5'd8);
        instr_tab[9]  = encode_2ri12(`OPC_ANDI, 12'hfff, 5'd1, 5'd9);
        instr_tab[10] = encode_2ri12(`OPC_XORI, 12'h800, 5'd9, 5'd10);
        instr_tab[11] = encode_2ri12(`OPC_ORI, 12'h800, 5'd4, 5'd11);
        // writes to r0, then reads of r0
        instr_tab[12] = encode_2ri12(`OPC_ADDI_W, 12'h001, 5'd1, 5'd0);
        instr_tab[13] = encode_1ri20(`OPC_LU12I_W, 20'hfffff, 5'd0);
        instr_tab[14] = encode_2ri12(`OPC_ADDI_W, 12'h123, 5'd0, 5'd12);
        // unknown encodings, both with r1 in the rd field
        instr_tab[15] = 32'hffff_ffe1;
        instr_tab[16] = 32'h0000_0001;
        // r1 must be untouched by the illegal words
        instr_tab[17] = encode_2ri12(`OPC_ORI, 12'h000, 5'd1, 5'd13);
        instr_tab[18] = encode_2ri12(`OPC_XORI, 12'hfff, 5'd1, 5'd1);
        instr_tab[19] = encode_2ri12(`OPC_ADDI_W, 12'hfff, 5'd1, 5'd14);
        instr_tab[20] = encode_2ri12(`OPC_ANDI, 12'h0f0, 5'd12, 5'd15);
        instr_tab[21] = encode_2ri12(`OPC_ADDI_W, 12'h000, 5'd0, 5'd16);
    endtask

    // reference model, one instruction in program order
    task automatic model_step(input logic [`DATA_W-1:0] pc, input instr_word_u w);
        logic [`DATA_W-1:0] src;
        logic [`DATA_W-1:0] val;
        logic [19:0]        i20;
        logic [11:0]        i12;
        logic [`GPR_AW-1:0] rd;
        logic               legal;
        i20   = w.f1ri20.imm20;
        i12   = w.f2ri12.imm12;
        rd    = w.f1ri20.rd;
        src   = ref_gpr[w.f2ri12.rj];
        val   = '0;
        legal = 1'b1;
        if (w.f1ri20.opcode == `OPC_LU12I_W) begin
            val = {i20, 12'h000};
        end else if (w.f1ri20.opcode == `OPC_PCADDU12I) begin
            val = pc + {i20, 12'h000};
        end else if (w.f1ri20.opcode == `OPC_PCADDI) begin
            val = pc + ({{12{i20[19]}}, i20} << 2);
        end else if (w.f2ri12.opcode == `OPC_ADDI_W) begin
            val = src + {{20{i12[11]}}, i12};
        end else if (w.f2ri12.opcode == `OPC_ANDI) begin
            val = src & {20'h00000, i12};
        end else if (w.f2ri12.opcode == `OPC_ORI) begin
            val = src | {20'h00000, i12};
        end else if (w.f2ri12.opcode == `OPC_XORI) begin
            val = src ^ {20'h00000, i12};
        end else begin
            legal = 1'b0;
        end
        if (legal && rd != '0) begin
            ref_gpr[rd] = val;
        end
        exp_rd.push_back(rd);
        exp_value.push_back(val);
        exp_we.push_back(legal && rd != '0);
        exp_illegal.push_back(!legal);
    endtask

    task automatic check_word(input string what, input logic [`DATA_W-1:0] got,
                              input logic [`DATA_W-1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_reg(input string what, input logic [`GPR_AW-1:0] got,
                             input logic [`GPR_AW-1:0] exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is r%0d, expected r%0d", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // producer, four-phase input handshake
    initial begin
        req_i     = 1'b0;
        pc_i      = '0;
        instr_i   = '0;
        res_ack_i = 1'b0;
        rst_n_i   = 1'b0;
        fill_table();
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        for (int i = 0; i < N_TESTS; i++) begin
            @(posedge clk_i);
            model_step(pc_tab[i], instr_tab[i]);
            pc_i    <= pc_tab[i];
            instr_i <= instr_tab[i];
            req_i   <= 1'b1;
            do @(posedge clk_i); while (!ack_o);
            req_i <= 1'b0;
            do @(posedge clk_i); while (ack_o);
        end
        while (recv_count < N_TESTS) @(posedge clk_i);
        // quiet period to catch duplicate results
        repeat (20) @(posedge clk_i);
        if (exp_rd.size() != 0) begin
            other_count++;
            $display("%0d expected results never arrived", exp_rd.size());
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_count);
        if (mismatch_count == 0 && other_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // consumer with random acknowledge delays
    initial begin
        int                 delay;
        string              tag;
        logic [`GPR_AW-1:0] e_rd;
        logic [`DATA_W-1:0] e_value;
        logic               e_we;
        logic               e_ill;
        forever begin
            @(posedge clk_i);
            if (rst_n_i && res_req_o && !res_ack_i) begin
                if (exp_rd.size() == 0) begin
                    other_count++;
                    $display("result at %0t arrived with no expected entry left", $time);
                end else begin
                    e_rd    = exp_rd.pop_front();
                    e_value = exp_value.pop_front();
                    e_we    = exp_we.pop_front();
                    e_ill   = exp_illegal.pop_front();
                    tag     = $sformatf("result %0d", recv_count);
                    check_flag({tag, " illegal"}, res_illegal_o, e_ill);
                    check_flag({tag, " we"}, res_we_o, e_we);
                    // rd and value carry no meaning for an illegal word
                    if (!e_ill) begin
                        check_reg({tag, " rd"}, res_rd_o, e_rd);
                        check_word({tag, " value"}, res_value_o, e_value);
                    end
                end
                recv_count++;
                delay = {$random(seed)} % 6;
                repeat (delay) @(posedge clk_i);
                res_ack_i <= 1'b1;
                do @(posedge clk_i); while (res_req_o);
                res_ack_i <= 1'b0;
            end
        end
    end

    // watchdog
    initial begin
        repeat (N_TESTS * 20 + 100) @(posedge clk_i);
        $display("watchdog expired, %0d of %0d results received", recv_count, N_TESTS);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- design/decode_exec_top.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defines.svh"

module decode_exec_top
    import core_types::*;
(
    input  logic               clk_i,
    input  logic               rst_n_i,

    // instruction handshake
    input  logic               req_i,
    input  logic [`DATA_W-1:0] pc_i,
    input  instr_word_u        instr_i,
    output logic               ack_o,

    // result handshake
    input  logic               res_ack_i,
    output logic               res_req_o,
    output logic [`GPR_AW-1:0] res_rd_o,
    output logic [`DATA_W-1:0] res_value_o,
    output logic               res_we_o,
    output logic               res_illegal_o
);

    // accept -> decode
    logic                acc_full;
    logic [`DATA_W-1:0]  acc_pc;
    instr_word_u         acc_instr;
    logic                dec_free;

    // decode -> execute
    logic                dec_full;
    logic [`DATA_W-1:0]  dec_pc;
    logic [`GPR_AW-1:0]  dec_rd;
    logic [`GPR_AW-1:0]  dec_rj;
    logic                dec_we;
    logic                dec_use_pc;
    logic [`DATA_W-1:0]  dec_imm;
    logic [`ALUOP_W-1:0] dec_aluop;
    logic                dec_illegal;
    logic                exe_free;

    // execute -> sender
    logic                exe_full;
    logic [`GPR_AW-1:0]  exe_rd;
    logic [`DATA_W-1:0]  exe_value;
    logic                exe_we;
    logic                exe_illegal;
    logic                snd_free;

    instr_accept u_accept (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .req_i       (req_i),
        .pc_i        (pc_i),
        .instr_i     (instr_i),
        .ack_o       (ack_o),
        .next_free_i (dec_free),
        .full_o      (acc_full),
        .pc_o        (acc_pc),
        .instr_o     (acc_instr)
    );

    decode_stage u_decode (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_full_i   (acc_full),
        .pc_i        (acc_pc),
        .instr_i     (acc_instr),
        .free_o      (dec_free),
        .next_free_i (exe_free),
        .full_o      (dec_full),
        .pc_o        (dec_pc),
        .rd_o        (dec_rd),
        .rj_o        (dec_rj),
        .we_o        (dec_we),
        .use_pc_o    (dec_use_pc),
        .imm_o       (dec_imm),
        .aluop_o     (dec_aluop),
        .illegal_o   (dec_illegal)
    );

    exec_stage u_exec (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .in_full_i   (dec_full),
        .pc_i        (dec_pc),
        .rd_i        (dec_rd),
        .rj_i        (dec_rj),
        .we_i        (dec_we),
        .use_pc_i    (dec_use_pc),
        .imm_i       (dec_imm),
        .aluop_i     (dec_aluop),
        .illegal_i   (dec_illegal),
        .free_o      (exe_free),
        .next_free_i (snd_free),
        .full_o      (exe_full),
        .rd_o        (exe_rd),
        .value_o     (exe_value),
        .we_o        (exe_we),
        .illegal_o   (exe_illegal)
    );

    result_sender u_sender (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .in_full_i     (exe_full),
        .rd_i          (exe_rd),
        .value_i       (exe_value),
        .we_i          (exe_we),
        .illegal_i     (exe_illegal),
        .free_o        (snd_free),
        .res_ack_i     (res_ack_i),
        .res_req_o     (res_req_o),
        .res_rd_o      (res_rd_o),
        .res_value_o   (res_value_o),
        .res_we_o      (res_we_o),
        .res_illegal_o (res_illegal_o)
    );

endmodule

`default_nettype wire

//--- design/result_sender.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defines.svh"

module result_sender (
    input  logic               clk_i,
    input  logic               rst_n_i,

    // from execute
    input  logic               in_full_i,
    input  logic [`GPR_AW-1:0] rd_i,
    input  logic [`DATA_W-1:0] value_i,
    input  logic               we_i,
    input  logic               illegal_i,
    output logic               free_o,

    // four-phase result side
    input  logic               res_ack_i,
    output logic               res_req_o,
    output logic [`GPR_AW-1:0] res_rd_o,
    output logic [`DATA_W-1:0] res_value_o,
    output logic               res_we_o,
    output logic               res_illegal_o
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1;
    localparam logic [1:0] S_DROP = 2'd2;

    logic [1:0] state;

    // one result at a time
    assign free_o = (state == S_IDLE);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state         <= S_IDLE;
            res_req_o     <= 1'b0;
            res_rd_o      <= '0;
            res_value_o   <= '0;
            res_we_o      <= 1'b0;
            res_illegal_o <= 1'b0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (in_full_i) begin
                        state         <= S_REQ;
                        res_rd_o      <= rd_i;
                        res_value_o   <= value_i;
                        res_we_o      <= we_i;
                        res_illegal_o <= illegal_i;
                    end
                end
                S_REQ: begin
                    // req goes up the edge after the take
                    if (!res_req_o) begin
                        res_req_o <= 1'b1;
                    end else if (res_ack_i) begin
                        res_req_o <= 1'b0;
                        state     <= S_DROP;
                    end
                end
                S_DROP: begin
                    // wait for the consumer to release ack
                    if (!res_ack_i) begin
                        state <= S_IDLE;
                    end
                end
                default: begin
                    state     <= S_IDLE;
                    res_req_o <= 1'b0;
                end
            endcase
        end
    end

    // request and payload held until acknowledged
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        res_req_o && !res_ack_i |=> res_req_o && $stable(res_rd_o)
            && $stable(res_value_o) && $stable(res_we_o) && $stable(res_illegal_o));

endmodule

`default_nettype wire

//--- design/exec_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defines.svh"

module exec_stage (
    input  logic                clk_i,
    input  logic                rst_n_i,

    // decoded operation
    input  logic                in_full_i,
    input  logic [`DATA_W-1:0]  pc_i,
    input  logic [`GPR_AW-1:0]  rd_i,
    input  logic [`GPR_AW-1:0]  rj_i,
    input  logic                we_i,
    input  logic                use_pc_i,
    input  logic [`DATA_W-1:0]  imm_i,
    input  logic [`ALUOP_W-1:0] aluop_i,
    input  logic                illegal_i,
    output logic                free_o,

    // result towards the sender
    input  logic                next_free_i,
    output logic                full_o,
    output logic [`GPR_AW-1:0]  rd_o,
    output logic [`DATA_W-1:0]  value_o,
    output logic                we_o,
    output logic                illegal_o
);

    logic [`DATA_W-1:0] gpr [`GPR_NUM];
    logic [`DATA_W-1:0] opa;
    logic [`DATA_W-1:0] result;
    logic               load;
    logic               wr_en;

    assign free_o = !full_o || next_free_i;
    assign load   = in_full_i && free_o;

    // r0 is never written so it keeps its reset zero
    assign opa = (use_pc_i == `SRC_SEL_PC) ? pc_i : gpr[rj_i];

    always_comb begin
        case (aluop_i)
            `ALU_LUI:   result = imm_i;
            `ALU_PCADD: result = opa + imm_i;
            `ALU_ADD:   result = opa + imm_i;
            `ALU_AND:   result = opa & imm_i;
            `ALU_OR:    result = opa | imm_i;
            `ALU_XOR:   result = opa ^ imm_i;
            default:    result = '0;
        endcase
    end

    assign wr_en = load && we_i && (rd_i != '0);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < `GPR_NUM; i++) begin
                gpr[i] <= '0;
            end
        end else if (wr_en) begin
            gpr[rd_i] <= result;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_o    <= 1'b0;
            rd_o      <= '0;
            value_o   <= '0;
            we_o      <= 1'b0;
            illegal_o <= 1'b0;
        end else if (load) begin
            full_o    <= 1'b1;
            rd_o      <= rd_i;
            value_o   <= result;
            // a write to r0 is reported as no write
            we_o      <= we_i && (rd_i != '0);
            illegal_o <= illegal_i;
        end else if (next_free_i) begin
            full_o <= 1'b0;
        end
    end

    // r0 reads zero for the whole run
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        gpr[0] == '0);

endmodule

`default_nettype wire

//--- design/decode_stage.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defines.svh"

module decode_stage
    import core_types::*;
(
    input  logic                clk_i,
    input  logic                rst_n_i,

    // from accept stage
    input  logic                in_full_i,
    input  logic [`DATA_W-1:0]  pc_i,
    input  instr_word_u         instr_i,
    output logic                free_o,

    // towards execute
    input  logic                next_free_i,
    output logic                full_o,
    output logic [`DATA_W-1:0]  pc_o,
    output logic [`GPR_AW-1:0]  rd_o,
    output logic [`GPR_AW-1:0]  rj_o,
    output logic                we_o,
    output logic                use_pc_o,
    output logic [`DATA_W-1:0]  imm_o,
    output logic [`ALUOP_W-1:0] aluop_o,
    output logic                illegal_o
);

    logic                a_valid;
    logic [`GPR_AW-1:0]  a_rd;
    logic                a_we;
    logic                a_use_pc;
    logic [`DATA_W-1:0]  a_imm;
    logic [`ALUOP_W-1:0] a_aluop;

    logic                b_valid;
    logic [`GPR_AW-1:0]  b_rd;
    logic [`GPR_AW-1:0]  b_rj;
    logic                b_we;
    logic [`DATA_W-1:0]  b_imm;
    logic [`ALUOP_W-1:0] b_aluop;

    logic                load;

    decoder_1RI20 u_dec_1ri20 (
        .instr_i  (instr_i),
        .valid_o  (a_valid),
        .rd_o     (a_rd),
        .we_o     (a_we),
        .use_pc_o (a_use_pc),
        .imm_o    (a_imm),
        .aluop_o  (a_aluop)
    );

    decoder_2RI12 u_dec_2ri12 (
        .instr_i (instr_i),
        .valid_o (b_valid),
        .rd_o    (b_rd),
        .rj_o    (b_rj),
        .we_o    (b_we),
        .imm_o   (b_imm),
        .aluop_o (b_aluop)
    );

    // empty, or handing over to execute this cycle
    assign free_o = !full_o || next_free_i;
    assign load   = in_full_i && free_o;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_o    <= 1'b0;
            pc_o      <= '0;
            rd_o      <= '0;
            rj_o      <= '0;
            we_o      <= 1'b0;
            use_pc_o  <= `SRC_SEL_RJ;
            imm_o     <= '0;
            aluop_o   <= '0;
            illegal_o <= 1'b0;
        end else if (load) begin
            full_o    <= 1'b1;
            pc_o      <= pc_i;
            // opcode prefixes are disjoint, at most one decoder hits
            if (a_valid) begin
                rd_o     <= a_rd;
                rj_o     <= '0;
                we_o     <= a_we;
                use_pc_o <= a_use_pc;
                imm_o    <= a_imm;
                aluop_o  <= a_aluop;
            end else begin
                rd_o     <= b_rd;
                rj_o     <= b_rj;
                we_o     <= b_we;
                use_pc_o <= `SRC_SEL_RJ;
                imm_o    <= b_imm;
                aluop_o  <= b_aluop;
            end
            illegal_o <= !(a_valid || b_valid);
        end else if (next_free_i) begin
            full_o <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/decoder_2RI12.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defines.svh"

// 2RI12 format, ADDI.W / ANDI / ORI / XORI
module decoder_2RI12
    import core_types::*;
(
    input  instr_word_u         instr_i,

    // high when the opcode belongs to this format
    output logic                valid_o,

    // register fields
    output logic [`GPR_AW-1:0]  rd_o,
    output logic [`GPR_AW-1:0]  rj_o,
    output logic                we_o,

    // immediate and alu operation
    output logic [`DATA_W-1:0]  imm_o,
    output logic [`ALUOP_W-1:0] aluop_o
);

    logic [11:0] imm12;

    assign imm12 = instr_i.f2ri12.imm12;

    always_comb begin
        valid_o = 1'b1;
        rd_o    = instr_i.f2ri12.rd;
        rj_o    = instr_i.f2ri12.rj;
        we_o    = 1'b1;
        // logical ops take the zero extended form
        imm_o   = {20'b0, imm12};
        aluop_o = '0;
        case (instr_i.f2ri12.opcode)
            `OPC_ADDI_W: begin
                imm_o   = {{20{imm12[11]}}, imm12};
                aluop_o = `ALU_ADD;
            end
            `OPC_ANDI: begin
                aluop_o = `ALU_AND;
            end
            `OPC_ORI: begin
                aluop_o = `ALU_OR;
            end
            `OPC_XORI: begin
                aluop_o = `ALU_XOR;
            end
            default: begin
                valid_o = 1'b0;
                rd_o    = '0;
                rj_o    = '0;
                we_o    = 1'b0;
                imm_o   = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/decoder_1RI20.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defines.svh"

// 1RI20 format, LU12I.W / PCADDI / PCADDU12I
module decoder_1RI20
    import core_types::*;
(
    input  instr_word_u         instr_i,

    // high when the opcode belongs to this format
    output logic                valid_o,

    // destination register
    output logic [`GPR_AW-1:0]  rd_o,
    output logic                we_o,

    // operand a from pc instead of rj
    output logic                use_pc_o,
    output logic [`DATA_W-1:0]  imm_o,
    output logic [`ALUOP_W-1:0] aluop_o
);

    logic [19:0] imm20;

    assign imm20 = instr_i.f1ri20.imm20;

    always_comb begin
        valid_o  = 1'b0;
        rd_o     = '0;
        we_o     = 1'b0;
        use_pc_o = `SRC_SEL_RJ;
        imm_o    = '0;
        aluop_o  = '0;
        case (instr_i.f1ri20.opcode)
            `OPC_LU12I_W: begin
                valid_o = 1'b1;
                rd_o    = instr_i.f1ri20.rd;
                we_o    = 1'b1;
                imm_o   = {imm20, 12'b0};
                aluop_o = `ALU_LUI;
            end
            `OPC_PCADDU12I: begin
                valid_o  = 1'b1;
                rd_o     = instr_i.f1ri20.rd;
                we_o     = 1'b1;
                use_pc_o = `SRC_SEL_PC;
                imm_o    = {imm20, 12'b0};
                aluop_o  = `ALU_PCADD;
            end
            `OPC_PCADDI: begin
                valid_o  = 1'b1;
                rd_o     = instr_i.f1ri20.rd;
                we_o     = 1'b1;
                use_pc_o = `SRC_SEL_PC;
                // word offset, sign extended
                imm_o    = {{10{imm20[19]}}, imm20, 2'b00};
                aluop_o  = `ALU_PCADD;
            end
            default: begin
                valid_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/instr_accept.sv
`default_nettype none
`timescale 1ns/1ps

`include "core_defines.svh"

module instr_accept
    import core_types::*;
(
    input  logic               clk_i,
    input  logic               rst_n_i,

    // four-phase request side
    input  logic               req_i,
    input  logic [`DATA_W-1:0] pc_i,
    input  instr_word_u        instr_i,
    output logic               ack_o,

    // towards decode
    input  logic               next_free_i,
    output logic               full_o,
    output logic [`DATA_W-1:0] pc_o,
    output instr_word_u        instr_o
);

    logic capture;

    // new request, not yet acked, and room in this stage
    assign capture = req_i && !ack_o && (!full_o || next_free_i);

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_o   <= 1'b0;
            full_o  <= 1'b0;
            pc_o    <= '0;
            instr_o <= '0;
        end else begin
            if (capture) begin
                full_o  <= 1'b1;
                pc_o    <= pc_i;
                instr_o <= instr_i;
            end else if (next_free_i) begin
                full_o  <= 1'b0;
            end

            // ack follows capture, drops once req is seen low
            if (capture) begin
                ack_o <= 1'b1;
            end else if (!req_i) begin
                ack_o <= 1'b0;
            end
        end
    end

    // ack only ever answers a live request
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i));

endmodule

`default_nettype wire

//--- design/core_types_pkg.sv
`default_nettype none

`include "core_defines.svh"

package core_types;

    // one instruction word seen through either format
    // 1RI20 {opcode[7], imm20[20], rd[5]}
    // 2RI12 {opcode[10], imm12[12], rj[5], rd[5]}
    typedef union packed {
        struct packed {
            logic [`OPC1_W-1:0] opcode;
            logic [19:0]        imm20;
            logic [`GPR_AW-1:0] rd;
        } f1ri20;
        struct packed {
            logic [`OPC2_W-1:0] opcode;
            logic [11:0]        imm12;
            logic [`GPR_AW-1:0] rj;
            logic [`GPR_AW-1:0] rd;
        } f2ri12;
    } instr_word_u;

endpackage

`default_nettype wire

//--- include/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath and register file sizes
`define DATA_W  32
`define GPR_NUM 32
`define GPR_AW  5

// opcode field widths of the two formats
`define OPC1_W 7
`define OPC2_W 10

// 1RI20 opcodes, instr[31:25]
`define OPC_LU12I_W   7'b0001010
`define OPC_PCADDI    7'b0001100
`define OPC_PCADDU12I 7'b0001110

// 2RI12 opcodes, instr[31:22]
`define OPC_ADDI_W 10'b0000001010
`define OPC_ANDI   10'b0000001101
`define OPC_ORI    10'b0000001110
`define OPC_XORI   10'b0000001111

// alu operations
`define ALUOP_W   3
`define ALU_LUI   3'd0
`define ALU_PCADD 3'd1
`define ALU_ADD   3'd2
`define ALU_AND   3'd3
`define ALU_OR    3'd4
`define ALU_XOR   3'd5

// first operand select
`define SRC_SEL_RJ 1'b0
`define SRC_SEL_PC 1'b1

`endif
